/* src/dsi_pkg.sv */
package dsi_pkg;

    // bytes in one user FIFO word and in one lanes controller word
    localparam int unsigned BYTES_PER_WORD = 4;

    localparam logic [15:0] CRC_INIT           = 16'hFFFF; // payload checksum seed
    localparam logic [15:0] CRC_POLY_REFLECTED = 16'h8408; // x^16 + x^12 + x^5 + 1, lsb first

    // low nibbles of the data types that carry a word count and a payload
    localparam logic [3:0] DT_NIB_LONG_WRITE = 4'h9; // null, blanking, generic and DCS long write
    localparam logic [3:0] DT_NIB_PIXEL_D    = 4'hD; // packed pixel streams
    localparam logic [3:0] DT_NIB_PIXEL_E    = 4'hE; // packed and loosely packed pixel streams

    // parity masks over the 24 header bits, entry n gives ECC bit n
    localparam logic [5:0][23:0] ECC_MASK = {
        24'hEFFC00,
        24'hDF03F0,
        24'hB8E38E,
        24'h749A6D,
        24'hF2555B,
        24'hF12CB7
    };

    // one FIFO word seen either as a packet header or as four payload bytes
    typedef union packed {
        struct packed {
            logic [7:0]  spare;      // ECC goes here on the way out
            logic [15:0] word_count; // payload bytes of a long packet
            logic [7:0]  data_id;    // virtual channel and data type
        } hdr;
        logic [BYTES_PER_WORD-1:0][7:0] bytes; // byte 0 leaves first
    } usr_word_t;

    function automatic logic is_long_packet(input logic [7:0] data_id);
        logic [3:0] nib;
        nib = data_id[3:0];
        return (nib == DT_NIB_LONG_WRITE) ||
               (nib == DT_NIB_PIXEL_D) ||
               (nib == DT_NIB_PIXEL_E);
    endfunction

    // six bit hamming code of the header, top two bits stay zero
    function automatic logic [7:0] header_ecc(input logic [23:0] header);
        logic [7:0] ecc;
        ecc = 8'h00;
        for (int i = 0; i < 6; i++)
        begin
            ecc[i] = ^(header & ECC_MASK[i]);
        end
        return ecc;
    endfunction

endpackage

/* src/crc_byte_lane.sv */
`timescale 1ns/1ps

module crc_byte_lane
    import dsi_pkg::*;
(
    input  logic [15:0] crc_in,
    input  logic [7:0]  data_byte,
    input  logic        byte_en,
    output logic [15:0] crc_out
);

    logic [15:0] crc_work;

    always_comb
    begin
        crc_work = crc_in ^ {8'h00, data_byte}; // byte enters at the lsb end
        for (int i = 0; i < 8; i++)
        begin
            if (crc_work[0])
                crc_work = (crc_work >> 1) ^ CRC_POLY_REFLECTED;
            else
                crc_work = crc_work >> 1;
        end
        crc_out = byte_en ? crc_work : crc_in; // disabled lanes pass the running value on
    end

endmodule

/* src/packet_sequencer.sv */
`timescale 1ns/1ps

module packet_sequencer
    import dsi_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      reset_stop_read_data_hs,

    input  usr_word_t                 usr_fifo_data,
    input  logic                      usr_fifo_empty,
    output logic                      usr_fifo_read,

    input  logic                      seq_take,
    output usr_word_t                 seq_word,
    output logic [BYTES_PER_WORD-1:0] seq_byte_en,
    output logic                      seq_is_header,
    output logic                      seq_crc_last,
    output logic                      seq_valid
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;

    logic [1:0]                state;
    logic [15:0]               bytes_left; // payload bytes not yet offered
    logic                      hdr_long;
    logic                      hdr_zero_count;
    logic [7:0]                hdr_ecc;
    logic [BYTES_PER_WORD-1:0] tail_en;

    // header view of the word at the FIFO head
    assign hdr_long       = is_long_packet(usr_fifo_data.hdr.data_id);
    assign hdr_zero_count = (usr_fifo_data.hdr.word_count == 16'd0);
    assign hdr_ecc        = header_ecc({usr_fifo_data.hdr.word_count, usr_fifo_data.hdr.data_id});

    // byte lanes of a partly filled last word
    always_comb
    begin
        case (bytes_left[1:0])
            2'd1:    tail_en = 4'b0001;
            2'd2:    tail_en = 4'b0011;
            2'd3:    tail_en = 4'b0111;
            default: tail_en = 4'b1111;
        endcase
    end

    always_comb
    begin
        seq_word      = usr_fifo_data;
        seq_byte_en   = '1;
        seq_is_header = 1'b0;
        seq_crc_last  = 1'b0;
        seq_valid     = 1'b0;
        case (state)
            ST_HEADER:
            begin
                seq_word.hdr.spare = hdr_ecc; // spare byte carries the ECC
                seq_is_header      = 1'b1;
                seq_crc_last       = hdr_long && hdr_zero_count; // checksum follows at once
                seq_valid          = !usr_fifo_empty;
            end
            ST_PAYLOAD:
            begin
                seq_word.bytes = usr_fifo_data.bytes;
                if (bytes_left < 16'(BYTES_PER_WORD))
                    seq_byte_en = tail_en;
                seq_crc_last = (bytes_left <= 16'(BYTES_PER_WORD));
                seq_valid    = !usr_fifo_empty; // an empty FIFO mid packet just waits
            end
            default:
            begin
                seq_valid = 1'b0;
            end
        endcase
    end

    assign usr_fifo_read = seq_take && seq_valid; // show-ahead, so the pop and the use coincide

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
        begin
            state      <= ST_IDLE;
            bytes_left <= 16'd0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (!usr_fifo_empty)
                        state <= ST_HEADER;
                end
                ST_HEADER:
                begin
                    if (seq_take)
                    begin
                        if (hdr_long && !hdr_zero_count)
                        begin
                            state      <= ST_PAYLOAD;
                            bytes_left <= usr_fifo_data.hdr.word_count;
                        end
                        else
                        begin
                            state <= ST_IDLE; // short packet or empty payload is done
                        end
                    end
                end
                ST_PAYLOAD:
                begin
                    if (seq_take)
                    begin
                        if (seq_crc_last)
                            state <= ST_IDLE;
                        else
                            bytes_left <= bytes_left - 16'(BYTES_PER_WORD);
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/crc_word_packer.sv */
`timescale 1ns/1ps

module crc_word_packer
    import dsi_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      reset_stop_read_data_hs,

    input  usr_word_t                 seq_word,
    input  logic [BYTES_PER_WORD-1:0] seq_byte_en,
    input  logic                      seq_is_header,
    input  logic                      seq_crc_last,
    input  logic                      seq_valid,
    output logic                      seq_take,

    output logic [15:0]               crc_state,
    input  logic [15:0]               crc_next,

    output logic [31:0]               iface_write_data,
    output logic [3:0]                iface_write_strb,
    output logic                      iface_write_rqst,
    output logic                      iface_last_word,
    input  logic                      iface_data_rqst
);

    logic        out_valid;    // a word is on the lanes controller bus
    logic [31:0] out_data;
    logic [3:0]  out_strb;
    logic        out_last;
    logic        write_rqst_q;
    logic [15:0] crc_q;
    logic [15:0] carry_bytes;  // checksum bytes that did not fit the last word
    logic [1:0]  carry_cnt;

    logic        advance;
    logic [2:0]  byte_cnt;
    logic [2:0]  total_cnt;
    logic [15:0] crc_final;
    logic [31:0] masked_word;
    logic [47:0] merged;
    logic        word_last;

    function automatic logic [3:0] strb_from_count(input logic [2:0] cnt);
        logic [3:0] strb;
        case (cnt)
            3'd0:    strb = 4'b0000;
            3'd1:    strb = 4'b0001;
            3'd2:    strb = 4'b0011;
            3'd3:    strb = 4'b0111;
            default: strb = 4'b1111;
        endcase
        return strb;
    endfunction

    // the output register frees up when empty or when its word is taken
    assign advance  = !out_valid || iface_data_rqst;
    assign seq_take = advance && (carry_cnt == 2'd0) && seq_valid;

    assign byte_cnt  = {2'b00, seq_byte_en[0]} + {2'b00, seq_byte_en[1]} +
                       {2'b00, seq_byte_en[2]} + {2'b00, seq_byte_en[3]};
    assign total_cnt = byte_cnt + (seq_crc_last ? 3'd2 : 3'd0);
    assign crc_final = seq_is_header ? CRC_INIT : crc_next; // an empty payload keeps the seed

    always_comb
    begin
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
            masked_word[8*i +: 8] = seq_byte_en[i] ? seq_word.bytes[i] : 8'h00;
        end
    end

    // checksum lands right after the last valid byte, low byte first
    always_comb
    begin
        merged = {16'h0000, masked_word};
        if (seq_crc_last)
            merged = merged | ({32'h0, crc_final} << {byte_cnt, 3'b000});
    end

    assign word_last = (seq_is_header && !is_long_packet(seq_word.hdr.data_id)) ||
                       (seq_crc_last && (total_cnt <= 3'd4));

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
        begin
            out_valid    <= 1'b0;
            out_strb     <= 4'b0000;
            out_last     <= 1'b0;
            write_rqst_q <= 1'b0;
            carry_cnt    <= 2'd0;
            crc_q        <= CRC_INIT;
        end
        else
        begin
            write_rqst_q <= seq_take && seq_is_header; // only the first cycle of the header word
            if (advance)
            begin
                if (carry_cnt != 2'd0)
                begin
                    out_valid <= 1'b1;
                    out_strb  <= strb_from_count({1'b0, carry_cnt});
                    out_last  <= 1'b1;
                    carry_cnt <= 2'd0;
                end
                else if (seq_valid)
                begin
                    out_valid <= 1'b1;
                    out_strb  <= strb_from_count(total_cnt);
                    out_last  <= word_last;
                    carry_cnt <= (total_cnt > 3'd4) ? 2'(total_cnt - 3'd4) : 2'd0;
                    crc_q     <= seq_is_header ? CRC_INIT : crc_next;
                end
                else
                begin
                    out_valid <= 1'b0;
                    out_strb  <= 4'b0000;
                    out_last  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (advance)
        begin
            if (carry_cnt != 2'd0)
                out_data <= {16'h0000, carry_bytes};
            else if (seq_valid)
            begin
                out_data    <= merged[31:0];
                carry_bytes <= merged[47:32];
            end
        end
    end

    assign crc_state        = crc_q;
    assign iface_write_data = out_data;
    assign iface_write_strb = out_strb;
    assign iface_write_rqst = write_rqst_q;
    assign iface_last_word  = out_last;

endmodule

/* src/dsi_packet_assembler.sv */
`timescale 1ns/1ps

module dsi_packet_assembler
    import dsi_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset_stop_read_data_hs,

    input  logic [31:0] usr_fifo_data,
    input  logic        usr_fifo_empty,
    output logic        usr_fifo_read,

    output logic [31:0] iface_write_data,
    output logic [3:0]  iface_write_strb,
    output logic        iface_write_rqst,
    output logic        iface_last_word,
    input  logic        iface_data_rqst
);

    usr_word_t                      seq_word;
    logic [BYTES_PER_WORD-1:0]      seq_byte_en;
    logic                           seq_is_header;
    logic                           seq_crc_last;
    logic                           seq_valid;
    logic                           seq_take;

    // entry 0 is the packer register, the last entry is the checksum after the whole word
    logic [BYTES_PER_WORD:0][15:0]  crc_chain;

    packet_sequencer u_sequencer (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .usr_fifo_data           (usr_fifo_data),
        .usr_fifo_empty          (usr_fifo_empty),
        .seq_take                (seq_take),
        .usr_fifo_read           (usr_fifo_read),
        .seq_word                (seq_word),
        .seq_byte_en             (seq_byte_en),
        .seq_is_header           (seq_is_header),
        .seq_crc_last            (seq_crc_last),
        .seq_valid               (seq_valid)
    );

    genvar gi;
    for (gi = 0; gi < BYTES_PER_WORD; gi++)
    begin : g_crc_lane
        crc_byte_lane u_lane (
            .crc_in    (crc_chain[gi]),
            .data_byte (seq_word.bytes[gi]),
            .byte_en   (seq_byte_en[gi]),
            .crc_out   (crc_chain[gi+1])
        );
    end

    crc_word_packer u_packer (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .seq_word                (seq_word),
        .seq_byte_en             (seq_byte_en),
        .seq_is_header           (seq_is_header),
        .seq_crc_last            (seq_crc_last),
        .seq_valid               (seq_valid),
        .crc_next                (crc_chain[BYTES_PER_WORD]),
        .iface_data_rqst         (iface_data_rqst),
        .seq_take                (seq_take),
        .crc_state               (crc_chain[0]),
        .iface_write_data        (iface_write_data),
        .iface_write_strb        (iface_write_strb),
        .iface_write_rqst        (iface_write_rqst),
        .iface_last_word         (iface_last_word)
    );

endmodule

/* verification/tb_dsi_packet_assembler.sv */
`timescale 1ns/1ps

module tb_dsi_packet_assembler;

    localparam int SHORT_COUNT     = 8;
    localparam int LARGE_COUNT     = 6;
    localparam int BURST_COUNT     = 6;
    localparam int RESET_CYCLES    = 24;
    localparam int NUM_PACKETS     = SHORT_COUNT + 2 * (10 + LARGE_COUNT) + BURST_COUNT + 3;
    localparam int WATCHDOG_CYCLES = 200 * NUM_PACKETS + 1000;
    localparam int MAX_PAYLOAD     = 256;

    logic        clk_sys;
    logic        reset_stop_read_data_hs;
    logic [31:0] usr_fifo_data;
    logic        usr_fifo_empty;
    logic        usr_fifo_read;
    logic [31:0] iface_write_data;
    logic [3:0]  iface_write_strb;
    logic        iface_write_rqst;
    logic        iface_last_word;
    logic        iface_data_rqst;

    logic [31:0] fifo_q [$];   // show-ahead FIFO contents with the head at index 0
    logic [31:0] exp_data [$];
    logic [3:0]  exp_strb [$];
    logic        exp_last [$];
    logic        exp_first [$];
    logic [7:0]  payload_bytes [0:MAX_PAYLOAD-1];

    logic        pop_pending;
    logic        rqst_seen;    // a write request arrived for the burst still to start
    logic        stall_en;
    string       test_name;
    int          errors;
    int          checks;
    int          words_taken;
    int          base;
    int          wait_cnt;
    int unsigned seed;
    int unsigned scratch;
    int          large_wc [0:LARGE_COUNT-1];

    dsi_packet_assembler dut (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .usr_fifo_data           (usr_fifo_data),
        .usr_fifo_empty          (usr_fifo_empty),
        .usr_fifo_read           (usr_fifo_read),
        .iface_write_data        (iface_write_data),
        .iface_write_strb        (iface_write_strb),
        .iface_write_rqst        (iface_write_rqst),
        .iface_last_word         (iface_last_word),
        .iface_data_rqst         (iface_data_rqst)
    );

    always #4 clk_sys = ~clk_sys;

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // one parity equation of the DSI header ECC per bit
    function automatic logic [7:0] ecc_ref(input logic [23:0] d);
        logic [7:0] p;
        p    = 8'h00;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16] ^
               d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17] ^
               d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18] ^
               d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19] ^
               d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19] ^
               d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18] ^
               d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // bit serial CCITT checksum taking the lsb of each byte first
    function automatic logic [15:0] crc_ref(input int n);
        logic [15:0] crc;
        logic        fb;
        crc = 16'hFFFF;
        for (int i = 0; i < n; i++)
        begin
            for (int b = 0; b < 8; b++)
            begin
                fb  = crc[0] ^ payload_bytes[i][b];
                crc = crc >> 1;
                if (fb)
                    crc = crc ^ 16'h8408;
            end
        end
        return crc;
    endfunction

    // expected burst of one packet as the byte stream cut into words of four
    task automatic expect_packet(input logic is_long, input logic [23:0] hdr);
        logic [15:0] crc;
        logic [31:0] word;
        logic [3:0]  strb;
        int          wc;
        int          total;
        int          idx;
        exp_data.push_back({ecc_ref(hdr), hdr});
        exp_strb.push_back(4'b1111);
        exp_last.push_back(!is_long);
        exp_first.push_back(1'b1);
        if (is_long)
        begin
            wc    = hdr[23:8];
            crc   = crc_ref(wc);
            total = wc + 2;
            for (int i = 0; i < total; i += 4)
            begin
                word = 32'h0;
                strb = 4'b0000;
                for (int k = 0; k < 4; k++)
                begin
                    idx = i + k;
                    if (idx < wc)
                        word[8*k +: 8] = payload_bytes[idx];
                    else if (idx == wc)
                        word[8*k +: 8] = crc[7:0];
                    else if (idx == wc + 1)
                        word[8*k +: 8] = crc[15:8];
                    strb[k] = (idx < total);
                end
                exp_data.push_back(word);
                exp_strb.push_back(strb);
                exp_last.push_back(i + 4 >= total);
                exp_first.push_back(1'b0);
            end
        end
    endtask

    task automatic update_fifo_outputs();
        usr_fifo_empty = (fifo_q.size() == 0);
        usr_fifo_data  = (fifo_q.size() != 0) ? fifo_q[0] : 32'h0;
    endtask

    task automatic push_packet(input logic is_long, input logic [7:0] data_id,
                               input logic [15:0] wc);
        logic [31:0] word;
        int          nwords;
        word        = $urandom;               // spare byte is random since the DUT overwrites it
        word[23:0]  = {wc, data_id};
        fifo_q.push_back(word);
        if (is_long)
        begin
            nwords = (wc + 3) / 4;
            for (int w = 0; w < nwords; w++)
            begin
                word = $urandom;
                fifo_q.push_back(word);
                for (int k = 0; k < 4; k++)
                    if (4 * w + k < wc)
                        payload_bytes[4*w + k] = word[8*k +: 8];
            end
        end
        expect_packet(is_long, {wc, data_id});
        update_fifo_outputs();
    endtask

    function automatic logic [7:0] short_id();
        logic [7:0] id;
        id = $urandom;
        if (id[3:0] == 4'h9 || id[3:0] == 4'hD || id[3:0] == 4'hE)
            id[0] = ~id[0];                   // moves the type off the long ones
        return id;
    endfunction

    function automatic logic [7:0] long_id();
        logic [7:0] id;
        id = $urandom;
        case (id[5:4])
            2'd0:    id[3:0] = 4'h9;
            2'd1:    id[3:0] = 4'hD;
            default: id[3:0] = 4'hE;
        endcase
        return id;
    endfunction

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_data.size() != 0 || fifo_q.size() != 0) && n < limit)
        begin
            @(posedge clk_sys);
            n++;
        end
        if (exp_data.size() != 0)
        begin
            errors++;
            $display("missing words in %s: %0d expected words never came out",
                     test_name, exp_data.size());
            exp_data.delete();
            exp_strb.delete();
            exp_last.delete();
            exp_first.delete();
        end
        repeat (4) @(posedge clk_sys); // room for an unwanted extra word to show up
    endtask

    task automatic run_packet(input logic is_long, input logic [7:0] data_id,
                              input logic [15:0] wc);
        @(posedge clk_sys);
        #1;
        push_packet(is_long, data_id, wc);
        wait_drained(200);
    endtask

    task automatic take_word();
        logic [31:0] e_data;
        logic [3:0]  e_strb;
        logic        e_last;
        logic        e_first;
        logic [31:0] mask;
        words_taken++;
        if (exp_data.size() == 0)
        begin
            errors++;
            $display("extra word in %s: %h came out with no packet pending",
                     test_name, iface_write_data);
        end
        else
        begin
            e_data  = exp_data.pop_front();
            e_strb  = exp_strb.pop_front();
            e_last  = exp_last.pop_front();
            e_first = exp_first.pop_front();
            if (e_first)
            begin
                if (!rqst_seen)
                begin
                    errors++;
                    $display("no iface_write_rqst at the start of a burst in %s", test_name);
                end
                rqst_seen = 1'b0;
            end
            for (int k = 0; k < 4; k++)
                mask[8*k +: 8] = {8{iface_write_strb[k]}};
            check_value("strobe", e_strb, iface_write_strb);
            check_value("data", e_data & mask, iface_write_data & mask);
            check_value("last word", e_last, iface_last_word);
        end
    endtask

    // outputs and iface_data_rqst are settled at the falling edge before the take at the next rise
    always @(negedge clk_sys)
    begin
        pop_pending = usr_fifo_read;
        if (!reset_stop_read_data_hs)
        begin
            if (iface_write_rqst)
                rqst_seen = 1'b1;
            if (iface_write_strb != 4'b0000 && iface_data_rqst)
                take_word();
        end
    end

    always @(posedge clk_sys)
    begin
        #1;
        if (pop_pending && fifo_q.size() != 0)
            scratch = fifo_q.pop_front();
        pop_pending = 1'b0;
        update_fifo_outputs();
        iface_data_rqst = stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("watchdog expired after %0d cycles in %s, errors %0d",
                 WATCHDOG_CYCLES, test_name, errors);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        seed    = 32'h0938_321e;
        scratch = $urandom(seed);
        clk_sys                 = 1'b0;
        reset_stop_read_data_hs = 1'b1;
        usr_fifo_data           = 32'h0;
        usr_fifo_empty          = 1'b1;
        iface_data_rqst         = 1'b0;
        stall_en                = 1'b0;
        pop_pending             = 1'b0;
        rqst_seen               = 1'b0;
        errors                  = 0;
        checks                  = 0;
        words_taken             = 0;
        test_name               = "startup";
        repeat (2) @(posedge clk_sys);
        #1;
        reset_stop_read_data_hs = 1'b0;

        test_name = "short";
        for (int i = 0; i < SHORT_COUNT; i++)
            run_packet(1'b0, short_id(), $urandom);

        test_name = "long";
        for (int i = 0; i < LARGE_COUNT; i++)
            large_wc[i] = 10 + ($urandom % 55);
        for (int wc = 0; wc < 10; wc++)
            run_packet(1'b1, long_id(), wc);
        for (int i = 0; i < LARGE_COUNT; i++)
            run_packet(1'b1, long_id(), large_wc[i]);

        test_name = "backpressure";
        stall_en  = 1'b1;
        for (int wc = 0; wc < 10; wc++)
            run_packet(1'b1, long_id(), wc);
        for (int i = 0; i < LARGE_COUNT; i++)
            run_packet(1'b1, long_id(), large_wc[i]);
        stall_en  = 1'b0;

        test_name = "back_to_back";
        @(posedge clk_sys);
        #1;
        for (int i = 0; i < BURST_COUNT; i++)
        begin
            if (i % 2 == 1)
                push_packet(1'b1, long_id(), 3 + 5 * i);
            else
                push_packet(1'b0, short_id(), $urandom);
        end
        wait_drained(200 * BURST_COUNT);

        test_name = "reset";
        @(posedge clk_sys);
        #1;
        push_packet(1'b1, long_id(), 16'd40);
        push_packet(1'b0, short_id(), $urandom); // header waiting behind the cut packet
        base     = words_taken;
        wait_cnt = 0;
        while (words_taken < base + 3 && wait_cnt < 200)
        begin
            @(posedge clk_sys);
            wait_cnt++;
        end
        if (wait_cnt == 200)
        begin
            errors++;
            $display("no words came out before the reset in %s", test_name);
        end
        #1;
        reset_stop_read_data_hs = 1'b1;       // packet is cut off halfway
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk_sys);
            #1;
            check_value("write_rqst in reset", 1'b0, iface_write_rqst);
            check_value("last_word in reset", 1'b0, iface_last_word);
            check_value("fifo_read in reset", 1'b0, usr_fifo_read);
            check_value("strobe in reset", 4'b0000, iface_write_strb);
        end
        fifo_q.delete();
        exp_data.delete();
        exp_strb.delete();
        exp_last.delete();
        exp_first.delete();
        rqst_seen = 1'b0;
        update_fifo_outputs();
        reset_stop_read_data_hs = 1'b0;
        run_packet(1'b1, long_id(), 16'd7);

        $display("checks %0d, words %0d, errors %0d", checks, words_taken, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* sim.f */
src/dsi_pkg.sv
src/crc_byte_lane.sv
src/packet_sequencer.sv
src/crc_word_packer.sv
src/dsi_packet_assembler.sv
verification/tb_dsi_packet_assembler.sv
